/* rtl/data_memory.sv */
/*
 * byte-lane data memory: sized write port driven by store commit,
 * registered word read port
 */
`include "lsu_params.svh"

module data_memory
    import lsu_pkg::*;
(
    input  logic                          clock,
    input  logic                          write_en,
    input  logic [`ADDR_W-1:0]            write_addr,
    input  logic [`DATA_W-1:0]            write_data,
    input  mem_size_e                     write_size,
    input  logic [$clog2(`MEM_WORDS)-1:0] rd_addr,
    output logic [`DATA_W-1:0]            rd_data
);

    localparam int WIDX_W = $clog2(`MEM_WORDS);

    logic [3:0][7:0]     mem [`MEM_WORDS];
    logic [3:0]          lane_en;
    logic [3:0][7:0]     lane_data;
    logic [WIDX_W-1:0]   word_idx;

    assign word_idx = write_addr[2 +: WIDX_W];

    // lane select from size and low address bits, data replicated per lane
    always_comb begin
        case (write_size)
            MEM_BYTE: begin
                lane_en = 4'b0001 << write_addr[1:0];
                lane_data = {4{write_data[7:0]}};
            end
            MEM_HALF: begin
                lane_en = write_addr[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{write_data[15:0]}};
            end
            default: begin
                lane_en = 4'b1111;
                lane_data = write_data;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (write_en) begin
            for (int l = 0; l < 4; l++) begin
                if (lane_en[l]) begin
                    mem[word_idx][l] <= lane_data[l];
                end
            end
        end
        rd_data <= mem[rd_addr];
    end

    // queue delivers aligned stores only
    aligned_a: assert property (
        @(posedge clock)
        write_en |-> (write_size == MEM_BYTE)
                  || (write_size == MEM_HALF && !write_addr[0])
                  || (write_size == MEM_WORD && write_addr[1:0] == 2'b00)
    ) else $error("misaligned store to memory");

endmodule

/* rtl/lsu_params.svh */
/*
 * sizing defines for the store side of the load/store unit:
 * dispatch width, queue depth, ROB and PRF sizes, memory geometry
 */
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// stores dispatched per cycle
`define SQ_WAYS 2
// store queue entries, power of two
`define SQ_DEPTH 8

`define ROB_SIZE 32
`define PRF_SIZE 64

// data memory, 32-bit words behind a byte address
`define MEM_WORDS 64
`define ADDR_W 16
`define DATA_W 32

`endif

/* rtl/lsu_pkg.sv */
/*
 * shared types of the store unit: access size enum,
 * ROB and PRF index types, credit count type
 */
`include "lsu_params.svh"

package lsu_pkg;

    // access size of a store, also used as the memory write size
    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_e;

    // reorder buffer index
    typedef logic [$clog2(`ROB_SIZE)-1:0] rob_idx_t;

    // physical register tag
    typedef logic [$clog2(`PRF_SIZE)-1:0] prf_idx_t;

    // 0 .. SQ_DEPTH, one extra bit
    typedef logic [$clog2(`SQ_DEPTH):0] credit_t;

endpackage

/* rtl/lsu_top.sv */
/*
 * store side of the load/store unit:
 * dispatch credits, store queue and data memory
 */
`include "lsu_params.svh"

module lsu_top
    import lsu_pkg::*;
(
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               except,
    input  logic                               commit,
    input  logic [`SQ_WAYS-1:0]                disp_req,
    input  mem_size_e [`SQ_WAYS-1:0]           disp_size,
    input  logic [`SQ_WAYS-1:0][`DATA_W-1:0]   disp_data,
    input  logic [`SQ_WAYS-1:0]                disp_data_valid,
    input  rob_idx_t [`SQ_WAYS-1:0]            disp_rob_idx,
    input  logic [`SQ_WAYS-1:0]                cdb_valid,
    input  prf_idx_t [`SQ_WAYS-1:0]            cdb_tag,
    input  logic [`SQ_WAYS-1:0][`DATA_W-1:0]   cdb_data,
    input  logic [`SQ_WAYS-1:0]                alu_valid,
    input  rob_idx_t [`SQ_WAYS-1:0]            alu_rob_idx,
    input  logic [`SQ_WAYS-1:0][`ADDR_W-1:0]   alu_addr,
    input  logic [$clog2(`MEM_WORDS)-1:0]      rd_addr,
    output logic [`SQ_WAYS-1:0]                disp_accept,
    output credit_t                            free_credits,
    output logic                               write_en,
    output logic [`ADDR_W-1:0]                 write_addr,
    output logic [`DATA_W-1:0]                 write_data,
    output mem_size_e                          write_size,
    output logic [`DATA_W-1:0]                 rd_data
);

    logic credit_return;

    store_dispatch store_dispatch_inst (
        .clock         (clock),
        .reset         (reset),
        .except        (except),
        .disp_req      (disp_req),
        .credit_return (credit_return),
        .disp_accept   (disp_accept),
        .free_credits  (free_credits)
    );

    // accepted ways enter the queue in the same cycle
    store_queue store_queue_inst (
        .clock         (clock),
        .reset         (reset),
        .except        (except),
        .commit        (commit),
        .enable        (disp_accept),
        .size          (disp_size),
        .data          (disp_data),
        .data_valid    (disp_data_valid),
        .rob_idx       (disp_rob_idx),
        .cdb_valid     (cdb_valid),
        .cdb_tag       (cdb_tag),
        .cdb_data      (cdb_data),
        .alu_valid     (alu_valid),
        .alu_rob_idx   (alu_rob_idx),
        .alu_addr      (alu_addr),
        .write_en      (write_en),
        .write_addr    (write_addr),
        .write_data    (write_data),
        .write_size    (write_size),
        .credit_return (credit_return)
    );

    data_memory data_memory_inst (
        .clock      (clock),
        .write_en   (write_en),
        .write_addr (write_addr),
        .write_data (write_data),
        .write_size (write_size),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

endmodule

/* rtl/store_dispatch.sv */
/*
 * store dispatch stage: credit counter for free queue entries
 * and in-order acceptance of up to SQ_WAYS requests per cycle
 */
`include "lsu_params.svh"

module store_dispatch
    import lsu_pkg::*;
(
    input  logic                clock,
    input  logic                reset,
    input  logic                except,
    input  logic [`SQ_WAYS-1:0] disp_req,
    input  logic                credit_return,
    output logic [`SQ_WAYS-1:0] disp_accept,
    output credit_t             free_credits
);

    credit_t grant_count;

    // grant a prefix of requested ways, one credit each
    always_comb begin
        logic prefix_ok;
        prefix_ok = 1'b1;
        grant_count = '0;
        for (int i = 0; i < `SQ_WAYS; i++) begin
            disp_accept[i] = prefix_ok && disp_req[i] && (credit_t'(i) < free_credits);
            prefix_ok = disp_accept[i];
            grant_count = grant_count + credit_t'(disp_accept[i]);
        end
    end

    // returned credit shows up one cycle after the commit
    always_ff @(posedge clock) begin
        if (reset || except) begin
            free_credits <= credit_t'(`SQ_DEPTH);
        end else begin
            free_credits <= free_credits - grant_count + credit_t'(credit_return);
        end
    end

    // more credits than entries means a return without a matching dispatch
    credit_bound_a: assert property (
        @(posedge clock) disable iff (reset)
        free_credits <= credit_t'(`SQ_DEPTH)
    ) else $error("free_credits above queue depth");

endmodule

/* rtl/store_queue.sv */
/*
 * circular store queue with one-hot head and tail pointers,
 * CDB data capture, ALU address capture, commit to memory and flush
 */
`include "lsu_params.svh"

module store_queue
    import lsu_pkg::*;
(
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               except,
    input  logic                               commit,
    input  logic [`SQ_WAYS-1:0]                enable,
    input  mem_size_e [`SQ_WAYS-1:0]           size,
    input  logic [`SQ_WAYS-1:0][`DATA_W-1:0]   data,
    input  logic [`SQ_WAYS-1:0]                data_valid,
    input  rob_idx_t [`SQ_WAYS-1:0]            rob_idx,
    input  logic [`SQ_WAYS-1:0]                cdb_valid,
    input  prf_idx_t [`SQ_WAYS-1:0]            cdb_tag,
    input  logic [`SQ_WAYS-1:0][`DATA_W-1:0]   cdb_data,
    input  logic [`SQ_WAYS-1:0]                alu_valid,
    input  rob_idx_t [`SQ_WAYS-1:0]            alu_rob_idx,
    input  logic [`SQ_WAYS-1:0][`ADDR_W-1:0]   alu_addr,
    output logic                               write_en,
    output logic [`ADDR_W-1:0]                 write_addr,
    output logic [`DATA_W-1:0]                 write_data,
    output mem_size_e                          write_size,
    output logic                               credit_return
);

    localparam int TAG_W = $bits(prf_idx_t);

    function automatic logic [`SQ_DEPTH-1:0] rotl(input logic [`SQ_DEPTH-1:0] v);
        return {v[`SQ_DEPTH-2:0], v[`SQ_DEPTH-1]};
    endfunction

    // entry payload, data_q holds the PRF tag while data is pending
    mem_size_e            size_q [`SQ_DEPTH];
    logic [`DATA_W-1:0]   data_q [`SQ_DEPTH];
    rob_idx_t             rob_q  [`SQ_DEPTH];
    logic [`ADDR_W-1:0]   addr_q [`SQ_DEPTH];

    // entry control
    logic [`SQ_DEPTH-1:0] valid_q;
    logic [`SQ_DEPTH-1:0] data_valid_q;
    logic [`SQ_DEPTH-1:0] addr_valid_q;
    logic [`SQ_DEPTH-1:0] head_q;
    logic [`SQ_DEPTH-1:0] tail_q;

    // slot of each way, tail_way[SQ_WAYS] is the next tail
    logic [`SQ_WAYS:0][`SQ_DEPTH-1:0] tail_way;

    logic [`DATA_W-1:0]   new_data [`SQ_WAYS];
    logic [`SQ_WAYS-1:0]  new_dv;

    logic [`SQ_DEPTH-1:0]             ins_take;
    logic [$clog2(`SQ_WAYS)-1:0]      ins_src  [`SQ_DEPTH];
    logic [`SQ_DEPTH-1:0]             cdb_take;
    logic [`DATA_W-1:0]               cdb_word [`SQ_DEPTH];
    logic [`SQ_DEPTH-1:0][`SQ_WAYS-1:0] alu_hits;
    logic [`ADDR_W-1:0]               alu_word [`SQ_DEPTH];

    logic                 head_valid;
    logic                 head_dv;
    logic                 head_av;

    // consecutive slots from the tail for the enabled ways
    always_comb begin
        tail_way[0] = tail_q;
        for (int w = 0; w < `SQ_WAYS; w++) begin
            tail_way[w+1] = enable[w] ? rotl(tail_way[w]) : tail_way[w];
        end
    end

    // same-cycle CDB match on a store being dispatched
    always_comb begin
        for (int w = 0; w < `SQ_WAYS; w++) begin
            new_data[w] = data[w];
            new_dv[w] = data_valid[w];
            for (int k = 0; k < `SQ_WAYS; k++) begin
                if (!data_valid[w] && cdb_valid[k] && cdb_tag[k] == data[w][TAG_W-1:0]) begin
                    new_data[w] = cdb_data[k];
                    new_dv[w] = 1'b1;
                end
            end
        end
    end

    // per entry: insertion, CDB hit, ALU hit
    always_comb begin
        for (int e = 0; e < `SQ_DEPTH; e++) begin
            ins_take[e] = 1'b0;
            ins_src[e] = '0;
            cdb_take[e] = 1'b0;
            cdb_word[e] = '0;
            alu_hits[e] = '0;
            alu_word[e] = '0;
            for (int w = 0; w < `SQ_WAYS; w++) begin
                if (enable[w] && tail_way[w][e]) begin
                    ins_take[e] = 1'b1;
                    ins_src[e] = w[$clog2(`SQ_WAYS)-1:0];
                end
                if (valid_q[e] && !data_valid_q[e] && cdb_valid[w]
                        && cdb_tag[w] == data_q[e][TAG_W-1:0]) begin
                    cdb_take[e] = 1'b1;
                    cdb_word[e] = cdb_data[w];
                end
                if (valid_q[e] && !addr_valid_q[e] && alu_valid[w]
                        && alu_rob_idx[w] == rob_q[e]) begin
                    alu_hits[e][w] = 1'b1;
                    alu_word[e] = alu_addr[w];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int e = 0; e < `SQ_DEPTH; e++) begin
            if (ins_take[e]) begin
                size_q[e] <= size[ins_src[e]];
                data_q[e] <= new_data[ins_src[e]];
                rob_q[e] <= rob_idx[ins_src[e]];
            end else if (cdb_take[e]) begin
                data_q[e] <= cdb_word[e];
            end
            if (|alu_hits[e]) begin
                addr_q[e] <= alu_word[e];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset || except) begin
            valid_q <= '0;
            data_valid_q <= '0;
            addr_valid_q <= '0;
            head_q <= `SQ_DEPTH'(1);
            tail_q <= `SQ_DEPTH'(1);
        end else begin
            head_q <= commit ? rotl(head_q) : head_q;
            tail_q <= tail_way[`SQ_WAYS];
            for (int e = 0; e < `SQ_DEPTH; e++) begin
                if (ins_take[e]) begin
                    valid_q[e] <= 1'b1;
                    data_valid_q[e] <= new_dv[ins_src[e]];
                    addr_valid_q[e] <= 1'b0;
                end else begin
                    if (commit && head_q[e]) begin
                        valid_q[e] <= 1'b0;
                    end
                    if (cdb_take[e]) begin
                        data_valid_q[e] <= 1'b1;
                    end
                    if (|alu_hits[e]) begin
                        addr_valid_q[e] <= 1'b1;
                    end
                end
            end
        end
    end

    // head entry drives the memory write
    always_comb begin
        head_valid = 1'b0;
        head_dv = 1'b0;
        head_av = 1'b0;
        write_addr = '0;
        write_data = '0;
        write_size = MEM_BYTE;
        for (int e = 0; e < `SQ_DEPTH; e++) begin
            if (head_q[e]) begin
                head_valid = valid_q[e];
                head_dv = data_valid_q[e];
                head_av = addr_valid_q[e];
                write_addr = addr_q[e];
                write_data = data_q[e];
                write_size = size_q[e];
            end
        end
    end

    assign write_en = commit && head_valid;
    assign credit_return = commit;

    // outside commits only a complete head store
    commit_ready_a: assert property (
        @(posedge clock) disable iff (reset)
        commit |-> head_valid && head_dv && head_av
    ) else $error("commit while head store incomplete");

    // dispatch credits keep the tail off live entries
    no_overwrite_a: assert property (
        @(posedge clock) disable iff (reset)
        (ins_take & valid_q) == '0
    ) else $error("dispatch into a valid queue slot");

    for (genvar e = 0; e < `SQ_DEPTH; e++) begin : g_alu_chk
        alu_single_a: assert property (
            @(posedge clock) disable iff (reset)
            $onehot0(alu_hits[e])
        ) else $error("two ALU results for one store entry");
    end

endmodule

/* sim/lsu_tb.sv */
/*
 * testbench for the store unit: step table built from a reference model
 * of credits, queue order and memory bytes, then applied in a loop
 */
`include "lsu_params.svh"

module lsu_tb
    import lsu_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct {
        logic [`SQ_WAYS-1:0]              req;
        mem_size_e [`SQ_WAYS-1:0]         size;
        logic [`SQ_WAYS-1:0][`DATA_W-1:0] data;
        logic [`SQ_WAYS-1:0]              dv;
        rob_idx_t [`SQ_WAYS-1:0]          rob;
        logic [`SQ_WAYS-1:0]              cdb_v;
        prf_idx_t [`SQ_WAYS-1:0]          cdb_tag;
        logic [`SQ_WAYS-1:0][`DATA_W-1:0] cdb_data;
        logic [`SQ_WAYS-1:0]              alu_v;
        rob_idx_t [`SQ_WAYS-1:0]          alu_rob;
        logic [`SQ_WAYS-1:0][`ADDR_W-1:0] alu_addr;
        logic                             commit;
        logic                             except;
        logic                             rd_en;
        logic [5:0]                       rd_addr;
        logic [`SQ_WAYS-1:0]              exp_acc;
        credit_t                          exp_cred;
        logic [31:0]                      exp_rd;
        logic [`ADDR_W-1:0]               exp_waddr;
        logic [`DATA_W-1:0]               exp_wdata;
        mem_size_e                        exp_wsize;
    } step_t;

    typedef struct {
        mem_size_e   size;
        logic [31:0] data;
        logic        dv;
        rob_idx_t    rob;
        logic [15:0] addr;
        logic        av;
    } store_t;

    logic clock;
    logic reset;
    logic except;
    logic commit;
    logic [`SQ_WAYS-1:0]              disp_req;
    mem_size_e [`SQ_WAYS-1:0]         disp_size;
    logic [`SQ_WAYS-1:0][`DATA_W-1:0] disp_data;
    logic [`SQ_WAYS-1:0]              disp_data_valid;
    rob_idx_t [`SQ_WAYS-1:0]          disp_rob_idx;
    logic [`SQ_WAYS-1:0]              cdb_valid;
    prf_idx_t [`SQ_WAYS-1:0]          cdb_tag;
    logic [`SQ_WAYS-1:0][`DATA_W-1:0] cdb_data;
    logic [`SQ_WAYS-1:0]              alu_valid;
    rob_idx_t [`SQ_WAYS-1:0]          alu_rob_idx;
    logic [`SQ_WAYS-1:0][`ADDR_W-1:0] alu_addr;
    logic [5:0]                       rd_addr;
    logic [`SQ_WAYS-1:0]              disp_accept;
    credit_t                          free_credits;
    logic                             write_en;
    logic [`ADDR_W-1:0]               write_addr;
    logic [`DATA_W-1:0]               write_data;
    mem_size_e                        write_size;
    logic [`DATA_W-1:0]               rd_data;

    // reference model state
    step_t       step_q[$];
    step_t       cur;
    store_t      sq[$];
    logic [7:0]  mem_b [256];
    logic        word_written [64];
    int          m_credits = `SQ_DEPTH;
    int          next_rob = 0;
    int          next_tag = 10;
    int          cycles = 0;
    int          timeout_limit = 100;

    tb_clock_gen tb_clock_gen_inst (.clock(clock));

    lsu_top lsu_top_inst (.*);

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic clear_step();
        cur.req = '0;
        cur.dv = '0;
        cur.data = '0;
        cur.rob = '0;
        for (int w = 0; w < `SQ_WAYS; w++) begin
            cur.size[w] = MEM_WORD;
        end
        cur.cdb_v = '0;
        cur.cdb_tag = '0;
        cur.cdb_data = '0;
        cur.alu_v = '0;
        cur.alu_rob = '0;
        cur.alu_addr = '0;
        cur.commit = 1'b0;
        cur.except = 1'b0;
        cur.rd_en = 1'b0;
        cur.rd_addr = '0;
    endtask

    // rob index follows the accepted count, so a rejected way is re-sent unchanged
    task automatic set_disp(input int w, input mem_size_e sz, input logic [31:0] d,
                            input logic valid);
        cur.req[w] = 1'b1;
        cur.size[w] = sz;
        cur.data[w] = d;
        cur.dv[w] = valid;
        cur.rob[w] = rob_idx_t'(next_rob + w);
    endtask

    task automatic set_cdb(input int w, input logic [5:0] tag, input logic [31:0] d);
        cur.cdb_v[w] = 1'b1;
        cur.cdb_tag[w] = tag;
        cur.cdb_data[w] = d;
    endtask

    task automatic set_alu(input int w, input rob_idx_t r, input logic [15:0] a);
        cur.alu_v[w] = 1'b1;
        cur.alu_rob[w] = r;
        cur.alu_addr[w] = a;
    endtask

    task automatic set_read(input int word);
        cur.rd_en = 1'b1;
        cur.rd_addr = 6'(word);
    endtask

    function automatic logic [31:0] read_word(input logic [5:0] word);
        return {mem_b[4*word+3], mem_b[4*word+2], mem_b[4*word+1], mem_b[4*word]};
    endfunction

    function automatic logic [15:0] rand_addr(input mem_size_e sz);
        logic [15:0] base;
        base = 16'h80 + 16'(4 * ($urandom % 16));
        if (sz == MEM_BYTE) begin
            return base + 16'($urandom % 4);
        end else if (sz == MEM_HALF) begin
            return base + 16'(2 * ($urandom % 2));
        end
        return base;
    endfunction

    // byte lanes written by one committed store
    task automatic write_bytes(input store_t s);
        int a;
        int n;
        a = s.addr[7:0];
        n = (s.size == MEM_BYTE) ? 1 : (s.size == MEM_HALF) ? 2 : 4;
        for (int b = 0; b < n; b++) begin
            mem_b[a + b] = s.data[8*b +: 8];
        end
        word_written[a / 4] = 1'b1;
    endtask

    // expectations for cur, then advance the model by one cycle
    task automatic add_step();
        int n_acc;
        logic prefix_ok;
        store_t s;
        n_acc = 0;
        prefix_ok = 1'b1;
        cur.exp_cred = credit_t'(m_credits);
        for (int w = 0; w < `SQ_WAYS; w++) begin
            cur.exp_acc[w] = prefix_ok && cur.req[w] && (w < m_credits);
            prefix_ok = cur.exp_acc[w];
            n_acc += int'(cur.exp_acc[w]);
        end
        cur.exp_rd = read_word(cur.rd_addr);
        foreach (sq[i]) begin
            for (int w = 0; w < `SQ_WAYS; w++) begin
                if (!sq[i].dv && cur.cdb_v[w] && cur.cdb_tag[w] == sq[i].data[5:0]) begin
                    sq[i].data = cur.cdb_data[w];
                    sq[i].dv = 1'b1;
                end
                if (!sq[i].av && cur.alu_v[w] && cur.alu_rob[w] == sq[i].rob) begin
                    sq[i].addr = cur.alu_addr[w];
                    sq[i].av = 1'b1;
                end
            end
        end
        if (cur.commit) begin
            s = sq.pop_front();
            cur.exp_waddr = s.addr;
            cur.exp_wdata = s.data;
            cur.exp_wsize = s.size;
            write_bytes(s);
        end
        for (int w = 0; w < `SQ_WAYS; w++) begin
            if (cur.exp_acc[w]) begin
                s.size = cur.size[w];
                s.data = cur.data[w];
                s.dv = cur.dv[w];
                s.rob = cur.rob[w];
                s.addr = '0;
                s.av = 1'b0;
                for (int k = 0; k < `SQ_WAYS; k++) begin
                    if (!s.dv && cur.cdb_v[k] && cur.cdb_tag[k] == s.data[5:0]) begin
                        s.data = cur.cdb_data[k];
                        s.dv = 1'b1;
                    end
                end
                sq.push_back(s);
            end
        end
        next_rob += n_acc;
        if (cur.except) begin
            sq.delete();
            m_credits = `SQ_DEPTH;
        end else begin
            m_credits = m_credits - n_acc + int'(cur.commit);
        end
        step_q.push_back(cur);
        clear_step();
    endtask

    task automatic disp_pair();
        set_disp(0, MEM_WORD, 32'hC000_0000 + next_rob, 1'b1);
        set_disp(1, MEM_WORD, 32'hC000_0001 + next_rob, 1'b1);
    endtask

    task automatic build_directed();
        int r;
        clear_step();
        add_step();
        // ready data, sized writes into word 4
        r = next_rob;
        set_disp(0, MEM_WORD, 32'h1122_3344, 1'b1);
        add_step();
        set_alu(0, rob_idx_t'(r), 16'h0010);
        add_step();
        cur.commit = 1'b1;
        add_step();
        r = next_rob;
        set_read(4);
        set_disp(0, MEM_BYTE, 32'h0000_00AB, 1'b1);
        set_disp(1, MEM_HALF, 32'h0000_BEEF, 1'b1);
        add_step();
        set_alu(0, rob_idx_t'(r), 16'h0011);
        set_alu(1, rob_idx_t'(r + 1), 16'h0012);
        add_step();
        cur.commit = 1'b1;
        add_step();
        cur.commit = 1'b1;
        add_step();
        set_read(4);
        add_step();
        // data through the CDB, later and in the dispatch cycle
        r = next_rob;
        set_disp(0, MEM_WORD, 32'd5, 1'b0);
        add_step();
        set_cdb(1, 6'd5, 32'hCAFE_F00D);
        set_alu(0, rob_idx_t'(r), 16'h0020);
        add_step();
        set_disp(0, MEM_WORD, 32'd9, 1'b0);
        set_cdb(0, 6'd9, 32'h0BAD_BEEF);
        add_step();
        set_alu(0, rob_idx_t'(r + 1), 16'h0024);
        cur.commit = 1'b1;
        add_step();
        cur.commit = 1'b1;
        add_step();
        set_read(8);
        add_step();
        set_read(9);
        add_step();
        // run the credits dry with two-way dispatch
        r = next_rob;
        for (int n = 0; n < 5; n++) begin
            disp_pair();
            add_step();
        end
        for (int n = 0; n < 4; n++) begin
            set_alu(0, rob_idx_t'(r + 2 * n), 16'h0084);
            set_alu(1, rob_idx_t'(r + 2 * n + 1), 16'h0084);
            add_step();
        end
        disp_pair();
        cur.commit = 1'b1;
        add_step();
        disp_pair();
        add_step();
        disp_pair();
        add_step();
        // flush with stores pending, then reuse the address
        cur.except = 1'b1;
        add_step();
        r = next_rob;
        set_disp(0, MEM_BYTE, 32'h0000_005A, 1'b1);
        add_step();
        set_alu(0, rob_idx_t'(r), 16'h0084);
        add_step();
        cur.commit = 1'b1;
        add_step();
        set_read(33);
        add_step();
    endtask

    task automatic build_random();
        int nways;
        logic dv;
        logic [31:0] d;
        for (int n = 0; n < 40; n++) begin
            if (sq.size() > 0 && sq[0].dv && sq[0].av && ($urandom % 2)) begin
                cur.commit = 1'b1;
            end
            foreach (sq[i]) begin
                if (!sq[i].dv && ($urandom % 2)) begin
                    set_cdb(0, sq[i].data[5:0], $urandom);
                    break;
                end
            end
            foreach (sq[i]) begin
                if (!sq[i].av && ($urandom % 2)) begin
                    set_alu(0, sq[i].rob, rand_addr(sq[i].size));
                    break;
                end
            end
            nways = $urandom % 3;
            for (int w = 0; w < nways; w++) begin
                dv = 1'($urandom % 2);
                d = dv ? $urandom : 32'(next_tag % 64);
                if (!dv) begin
                    next_tag++;
                end
                set_disp(w, mem_size_e'($urandom % 3), d, dv);
                if (!dv && w == 1 && ($urandom % 4) == 0) begin
                    set_cdb(1, d[5:0], $urandom);
                end
            end
            add_step();
        end
        // complete and commit whatever is left
        while (sq.size() > 0) begin
            if (sq[0].dv && sq[0].av) begin
                cur.commit = 1'b1;
            end else begin
                if (!sq[0].dv) begin
                    set_cdb(0, sq[0].data[5:0], $urandom);
                end
                if (!sq[0].av) begin
                    set_alu(0, sq[0].rob, rand_addr(sq[0].size));
                end
            end
            add_step();
        end
        add_step();
        for (int w = 0; w < 64; w++) begin
            if (word_written[w]) begin
                set_read(w);
                add_step();
            end
        end
        add_step();
    endtask

    task automatic drive(input step_t s);
        disp_req = s.req;
        disp_size = s.size;
        disp_data = s.data;
        disp_data_valid = s.dv;
        disp_rob_idx = s.rob;
        cdb_valid = s.cdb_v;
        cdb_tag = s.cdb_tag;
        cdb_data = s.cdb_data;
        alu_valid = s.alu_v;
        alu_rob_idx = s.alu_rob;
        alu_addr = s.alu_addr;
        commit = s.commit;
        except = s.except;
        rd_addr = s.rd_addr;
    endtask

    always @(posedge clock) begin
        cycles++;
        if (cycles > timeout_limit) begin
            $display("timeout: the step table did not finish within %0d cycles", timeout_limit);
            $display("ERRORS FOUND");
            $fatal(1, "timeout");
        end
    end

    initial begin
        logic read_pending;
        logic [31:0] read_exp;
        void'($urandom(6171));
        foreach (word_written[w]) begin
            word_written[w] = 1'b0;
        end
        reset = 1'b1;
        clear_step();
        drive(cur);
        build_directed();
        build_random();
        timeout_limit = step_q.size() * 4 + 100;
        read_pending = 1'b0;
        read_exp = '0;
        repeat (5) @(negedge clock);
        reset = 1'b0;
        foreach (step_q[i]) begin
            @(negedge clock);
            if (read_pending) begin
                check_value("rd_data", rd_data, read_exp);
            end
            drive(step_q[i]);
            #1;
            check_value("disp_accept", 32'(disp_accept), 32'(step_q[i].exp_acc));
            check_value("free_credits", 32'(free_credits), 32'(step_q[i].exp_cred));
            check_value("write_en", 32'(write_en), 32'(step_q[i].commit));
            // head store on the write port while committing
            if (step_q[i].commit) begin
                check_value("write_addr", 32'(write_addr), 32'(step_q[i].exp_waddr));
                check_value("write_data", write_data, step_q[i].exp_wdata);
                check_value("write_size", 32'(write_size), 32'(step_q[i].exp_wsize));
            end
            read_pending = step_q[i].rd_en;
            read_exp = step_q[i].exp_rd;
        end
        @(negedge clock);
        if (read_pending) begin
            check_value("rd_data", rd_data, read_exp);
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* sim/tb_clock_gen.sv */
/*
 * free-running testbench clock, 10 ns period
 */
module tb_clock_gen (
    output logic clock
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clock = 1'b0;
    end

    always #5 clock = ~clock;

endmodule

/* tb.f */
+incdir+rtl
rtl/lsu_pkg.sv
rtl/store_dispatch.sv
rtl/store_queue.sv
rtl/data_memory.sv
rtl/lsu_top.sv
sim/tb_clock_gen.sv
sim/lsu_tb.sv
